/* hdl/lc4_core.sv */
`timescale 1ns/1ps

module lc4_core (
    input  logic                gwe,
    input  logic                i_rst_n,
    output lc4_pkg::word_t      o_imem_addr,
    input  lc4_pkg::word_t      i_imem_data,
    output lc4_pkg::word_t      o_dmem_addr,
    output logic                o_dmem_we,
    output lc4_pkg::word_t      o_dmem_wdata,
    input  lc4_pkg::word_t      i_dmem_rdata,
    output lc4_pkg::stall_t     o_trace_stall,
    output lc4_pkg::word_t      o_trace_pc,
    output lc4_pkg::word_t      o_trace_insn,
    output logic                o_trace_rf_we,
    output lc4_pkg::rsel_t      o_trace_rf_wsel,
    output lc4_pkg::word_t      o_trace_rf_data
);
    import lc4_pkg::*;

    rsel_t rs_sel;
    rsel_t rt_sel;
    word_t rs_data;
    word_t rt_data;

    // branch redirect and load hazard info from X
    logic  redirect;
    word_t target;
    logic  x_load;
    rsel_t x_rd;

    // MX bypass from M
    logic  m_fwd_en;
    rsel_t m_rd;
    word_t m_value;
    logic  m_nzp_en;
    nzp_t  m_nzp;

    lc4_stage_if dx ();
    lc4_stage_if xm ();
    lc4_wb_if    wb ();

    lc4_fetch_decode u_fetch_decode (
        .gwe         (gwe),
        .i_rst_n     (i_rst_n),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .i_redirect  (redirect),
        .i_target    (target),
        .i_x_load    (x_load),
        .i_x_rd      (x_rd),
        .o_rs_sel    (rs_sel),
        .o_rt_sel    (rt_sel),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .dx          (dx.src)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .wb        (wb.write)
    );

    lc4_execute u_execute (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .dx         (dx.dst),
        .xm         (xm.src),
        .wb         (wb.bypass),
        .i_m_fwd_en (m_fwd_en),
        .i_m_rd     (m_rd),
        .i_m_value  (m_value),
        .i_m_nzp_en (m_nzp_en),
        .i_m_nzp    (m_nzp),
        .o_redirect (redirect),
        .o_target   (target),
        .o_x_load   (x_load),
        .o_x_rd     (x_rd)
    );

    lc4_memory_wb u_memory_wb (
        .gwe             (gwe),
        .i_rst_n         (i_rst_n),
        .xm              (xm.dst),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_wdata    (o_dmem_wdata),
        .i_dmem_rdata    (i_dmem_rdata),
        .wb              (wb.src),
        .o_m_fwd_en      (m_fwd_en),
        .o_m_rd          (m_rd),
        .o_m_value       (m_value),
        .o_m_nzp_en      (m_nzp_en),
        .o_m_nzp         (m_nzp),
        .o_trace_stall   (o_trace_stall),
        .o_trace_pc      (o_trace_pc),
        .o_trace_insn    (o_trace_insn),
        .o_trace_rf_we   (o_trace_rf_we),
        .o_trace_rf_wsel (o_trace_rf_wsel),
        .o_trace_rf_data (o_trace_rf_data)
    );

endmodule

/* hdl/lc4_defs.svh */
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// opcodes in insn[15:12]
`define LC4_OP_BR    4'b0000
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101
`define LC4_OP_LDR   4'b0110
`define LC4_OP_STR   4'b0111
`define LC4_OP_CONST 4'b1001

// subcodes in insn[5:3], insn[5] set on ARITH selects add-immediate
`define LC4_SUB_ADD 3'b000
`define LC4_SUB_SUB 3'b010
`define LC4_SUB_AND 3'b000

// one-hot condition codes
`define LC4_NZP_N 3'b100
`define LC4_NZP_Z 3'b010
`define LC4_NZP_P 3'b001

`endif

/* hdl/lc4_execute.sv */
`timescale 1ns/1ps
`include "lc4_defs.svh"

module lc4_execute (
    input  logic           gwe,
    input  logic           i_rst_n,
    lc4_stage_if.dst       dx,
    lc4_stage_if.src       xm,
    lc4_wb_if.bypass       wb,
    input  logic           i_m_fwd_en,
    input  lc4_pkg::rsel_t i_m_rd,
    input  lc4_pkg::word_t i_m_value,
    input  logic           i_m_nzp_en,
    input  lc4_pkg::nzp_t  i_m_nzp,
    output logic           o_redirect,
    output lc4_pkg::word_t o_target,
    output logic           o_x_load,
    output lc4_pkg::rsel_t o_x_rd
);
    import lc4_pkg::*;

    word_t   x_pc;
    word_t   x_insn;
    rsel_t   x_rs;
    rsel_t   x_rt;
    rsel_t   x_rd;
    word_t   x_a;
    word_t   x_b;
    logic    x_rs_re;
    logic    x_rt_re;
    logic    x_rf_we;
    logic    x_nzp_we;
    logic    x_is_load;
    logic    x_is_store;
    logic    x_is_branch;
    stall_t  x_stall;
    nzp_t    nzp_q;
    nzp_t    cur_nzp;
    opcode_t opcode;
    word_t   rs_val;
    word_t   rt_val;
    word_t   imm5;
    word_t   imm6;
    word_t   imm9;
    word_t   result;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            x_stall     <= STALL_FLUSH;
            x_rs_re     <= 1'b0;
            x_rt_re     <= 1'b0;
            x_rf_we     <= 1'b0;
            x_nzp_we    <= 1'b0;
            x_is_load   <= 1'b0;
            x_is_store  <= 1'b0;
            x_is_branch <= 1'b0;
        end else begin
            x_stall     <= dx.stall;
            x_rs_re     <= dx.rs_re;
            x_rt_re     <= dx.rt_re;
            x_rf_we     <= dx.rf_we;
            x_nzp_we    <= dx.nzp_we;
            x_is_load   <= dx.is_load;
            x_is_store  <= dx.is_store;
            x_is_branch <= dx.is_branch;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc   <= dx.pc;
        x_insn <= dx.insn;
        x_rs   <= dx.rs;
        x_rt   <= dx.rt;
        x_rd   <= dx.rd;
        x_a    <= dx.a;
        x_b    <= dx.b;
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            nzp_q <= `LC4_NZP_Z;
        end else if (wb.nzp_we) begin
            nzp_q <= wb.nzp;
        end
    end

    // MX first, then WX, then the value read in D
    assign rs_val = (i_m_fwd_en && i_m_rd == x_rs) ? i_m_value :
                    (wb.we && wb.wsel == x_rs)     ? wb.data :
                    x_a;
    assign rt_val = (i_m_fwd_en && i_m_rd == x_rt) ? i_m_value :
                    (wb.we && wb.wsel == x_rt)     ? wb.data :
                    x_b;

    assign opcode = x_insn[15:12];
    assign imm5   = {{11{x_insn[4]}}, x_insn[4:0]};
    assign imm6   = {{10{x_insn[5]}}, x_insn[5:0]};
    assign imm9   = {{7{x_insn[8]}}, x_insn[8:0]};

    always_comb begin
        case (opcode)
            `LC4_OP_ARITH: begin
                if (x_insn[5]) begin
                    result = rs_val + imm5;
                end else if (x_insn[5:3] == `LC4_SUB_SUB) begin
                    result = rs_val - rt_val;
                end else begin
                    result = rs_val + rt_val;
                end
            end
            `LC4_OP_LOGIC: result = rs_val & rt_val;
            `LC4_OP_LDR,
            `LC4_OP_STR:   result = rs_val + imm6;
            `LC4_OP_CONST: result = imm9;
            default:       result = '0;
        endcase
    end

    // a load in M never reaches here as a branch source, it stalls the branch in D
    assign cur_nzp = i_m_nzp_en ? i_m_nzp :
                     wb.nzp_we  ? wb.nzp :
                     nzp_q;

    assign o_redirect = x_is_branch && |(x_insn[11:9] & cur_nzp);
    assign o_target   = x_pc + 16'd1 + imm9;
    assign o_x_load   = x_is_load;
    assign o_x_rd     = x_rd;

    assign xm.pc        = x_pc;
    assign xm.insn      = x_insn;
    assign xm.rs        = x_rs;
    assign xm.rt        = x_rt;
    assign xm.rd        = x_rd;
    assign xm.rs_re     = x_rs_re;
    assign xm.rt_re     = x_rt_re;
    assign xm.rf_we     = x_rf_we;
    assign xm.nzp_we    = x_nzp_we;
    assign xm.is_load   = x_is_load;
    assign xm.is_store  = x_is_store;
    assign xm.is_branch = x_is_branch;
    assign xm.a         = result;
    assign xm.b         = rt_val;
    assign xm.stall     = x_stall;

endmodule

/* hdl/lc4_fetch_decode.sv */
`timescale 1ns/1ps
`include "lc4_defs.svh"

module lc4_fetch_decode (
    input  logic           gwe,
    input  logic           i_rst_n,
    output lc4_pkg::word_t o_imem_addr,
    input  lc4_pkg::word_t i_imem_data,
    input  logic           i_redirect,
    input  lc4_pkg::word_t i_target,
    input  logic           i_x_load,
    input  lc4_pkg::rsel_t i_x_rd,
    output lc4_pkg::rsel_t o_rs_sel,
    output lc4_pkg::rsel_t o_rt_sel,
    input  lc4_pkg::word_t i_rs_data,
    input  lc4_pkg::word_t i_rt_data,
    lc4_stage_if.src       dx
);
    import lc4_pkg::*;

    word_t   pc_q;
    word_t   d_pc;
    word_t   d_insn;
    stall_t  d_stall;
    opcode_t opcode;
    logic [2:0] subop;
    rsel_t   rs;
    rsel_t   rt;
    rsel_t   rd;
    logic    rs_re;
    logic    rt_re;
    logic    rf_we;
    logic    nzp_we;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    load_use;
    logic    slot_ok;

    assign opcode = d_insn[15:12];
    assign subop  = d_insn[5:3];

    // unsupported opcodes and subcodes leave every enable clear
    always_comb begin
        rs        = d_insn[8:6];
        rt        = d_insn[2:0];
        rd        = d_insn[11:9];
        rs_re     = 1'b0;
        rt_re     = 1'b0;
        rf_we     = 1'b0;
        nzp_we    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            `LC4_OP_ARITH: begin
                if (d_insn[5] || subop == `LC4_SUB_ADD || subop == `LC4_SUB_SUB) begin
                    rs_re  = 1'b1;
                    rt_re  = !d_insn[5];
                    rf_we  = 1'b1;
                    nzp_we = 1'b1;
                end
            end
            `LC4_OP_LOGIC: begin
                if (!d_insn[5] && subop == `LC4_SUB_AND) begin
                    rs_re  = 1'b1;
                    rt_re  = 1'b1;
                    rf_we  = 1'b1;
                    nzp_we = 1'b1;
                end
            end
            `LC4_OP_LDR: begin
                rs_re   = 1'b1;
                rf_we   = 1'b1;
                nzp_we  = 1'b1;
                is_load = 1'b1;
            end
            `LC4_OP_STR: begin
                // store data register sits in the rd field
                rt       = d_insn[11:9];
                rs_re    = 1'b1;
                rt_re    = 1'b1;
                is_store = 1'b1;
            end
            `LC4_OP_CONST: begin
                rf_we  = 1'b1;
                nzp_we = 1'b1;
            end
            `LC4_OP_BR: begin
                // an empty mask is the canonical nop
                is_branch = |d_insn[11:9];
            end
            default: ;
        endcase
    end

    // store data (rt) is covered later by the WM bypass
    assign load_use = (d_stall == STALL_NONE) && i_x_load &&
                      ((rs_re && rs == i_x_rd) ||
                       (rt_re && !is_store && rt == i_x_rd) ||
                       is_branch);

    assign slot_ok = (d_stall == STALL_NONE) && !i_redirect && !load_use;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q    <= `LC4_RESET_PC;
            d_stall <= STALL_FLUSH;
        end else if (i_redirect) begin
            pc_q    <= i_target;
            d_stall <= STALL_FLUSH;
        end else if (!load_use) begin
            pc_q    <= pc_q + 16'd1;
            d_stall <= STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!load_use) begin
            d_pc   <= pc_q;
            d_insn <= i_imem_data;
        end
    end

    assign o_imem_addr = pc_q;
    assign o_rs_sel    = rs;
    assign o_rt_sel    = rt;

    assign dx.pc        = d_pc;
    assign dx.insn      = d_insn;
    assign dx.rs        = rs;
    assign dx.rt        = rt;
    assign dx.rd        = rd;
    assign dx.rs_re     = rs_re && slot_ok;
    assign dx.rt_re     = rt_re && slot_ok;
    assign dx.rf_we     = rf_we && slot_ok;
    assign dx.nzp_we    = nzp_we && slot_ok;
    assign dx.is_load   = is_load && slot_ok;
    assign dx.is_store  = is_store && slot_ok;
    assign dx.is_branch = is_branch && slot_ok;
    assign dx.a         = i_rs_data;
    assign dx.b         = i_rt_data;
    assign dx.stall     = i_redirect ? STALL_FLUSH :
                          load_use   ? STALL_LOAD_USE :
                          d_stall;

endmodule

/* hdl/lc4_if.sv */
`timescale 1ns/1ps

// one pipeline slot between two stages
interface lc4_stage_if;
    import lc4_pkg::*;

    word_t  pc;
    word_t  insn;
    rsel_t  rs;
    rsel_t  rt;
    rsel_t  rd;
    logic   rs_re;
    logic   rt_re;
    logic   rf_we;
    logic   nzp_we;
    logic   is_load;
    logic   is_store;
    logic   is_branch;
    // operands in D->X, result and store data in X->M
    word_t  a;
    word_t  b;
    stall_t stall;

    modport src (
        output pc, insn, rs, rt, rd, rs_re, rt_re, rf_we, nzp_we,
               is_load, is_store, is_branch, a, b, stall
    );
    modport dst (
        input  pc, insn, rs, rt, rd, rs_re, rt_re, rf_we, nzp_we,
               is_load, is_store, is_branch, a, b, stall
    );
endinterface

// writeback bus from W
interface lc4_wb_if;
    import lc4_pkg::*;

    logic  we;
    rsel_t wsel;
    word_t data;
    logic  nzp_we;
    nzp_t  nzp;

    modport src (output we, wsel, data, nzp_we, nzp);
    modport write (input we, wsel, data);
    modport bypass (input we, wsel, data, nzp_we, nzp);
endinterface

/* hdl/lc4_memory_wb.sv */
`timescale 1ns/1ps
`include "lc4_defs.svh"

module lc4_memory_wb (
    input  logic            gwe,
    input  logic            i_rst_n,
    lc4_stage_if.dst        xm,
    output lc4_pkg::word_t  o_dmem_addr,
    output logic            o_dmem_we,
    output lc4_pkg::word_t  o_dmem_wdata,
    input  lc4_pkg::word_t  i_dmem_rdata,
    lc4_wb_if.src           wb,
    output logic            o_m_fwd_en,
    output lc4_pkg::rsel_t  o_m_rd,
    output lc4_pkg::word_t  o_m_value,
    output logic            o_m_nzp_en,
    output lc4_pkg::nzp_t   o_m_nzp,
    output lc4_pkg::stall_t o_trace_stall,
    output lc4_pkg::word_t  o_trace_pc,
    output lc4_pkg::word_t  o_trace_insn,
    output logic            o_trace_rf_we,
    output lc4_pkg::rsel_t  o_trace_rf_wsel,
    output lc4_pkg::word_t  o_trace_rf_data
);
    import lc4_pkg::*;

    word_t  m_pc;
    word_t  m_insn;
    rsel_t  m_rd;
    rsel_t  m_rt;
    word_t  m_result;
    word_t  m_data;
    logic   m_rt_re;
    logic   m_rf_we;
    logic   m_nzp_we;
    logic   m_is_load;
    logic   m_is_store;
    stall_t m_stall;
    word_t  w_pc;
    word_t  w_insn;
    rsel_t  w_rd;
    word_t  w_result;
    word_t  w_load_data;
    logic   w_rf_we;
    logic   w_nzp_we;
    logic   w_is_load;
    stall_t w_stall;
    word_t  w_value;

    function automatic nzp_t nzp_of(input word_t v);
        if (v[15]) begin
            return `LC4_NZP_N;
        end else if (v == '0) begin
            return `LC4_NZP_Z;
        end
        return `LC4_NZP_P;
    endfunction

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            m_stall    <= STALL_FLUSH;
            m_rt_re    <= 1'b0;
            m_rf_we    <= 1'b0;
            m_nzp_we   <= 1'b0;
            m_is_load  <= 1'b0;
            m_is_store <= 1'b0;
            w_stall    <= STALL_FLUSH;
            w_rf_we    <= 1'b0;
            w_nzp_we   <= 1'b0;
            w_is_load  <= 1'b0;
        end else begin
            m_stall    <= xm.stall;
            m_rt_re    <= xm.rt_re;
            m_rf_we    <= xm.rf_we;
            m_nzp_we   <= xm.nzp_we;
            m_is_load  <= xm.is_load;
            m_is_store <= xm.is_store;
            w_stall    <= m_stall;
            w_rf_we    <= m_rf_we;
            w_nzp_we   <= m_nzp_we;
            w_is_load  <= m_is_load;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc        <= xm.pc;
        m_insn      <= xm.insn;
        m_rd        <= xm.rd;
        m_rt        <= xm.rt;
        m_result    <= xm.a;
        m_data      <= xm.b;
        w_pc        <= m_pc;
        w_insn      <= m_insn;
        w_rd        <= m_rd;
        w_result    <= m_result;
        w_load_data <= i_dmem_rdata;
    end

    assign w_value = w_is_load ? w_load_data : w_result;

    assign o_dmem_addr  = m_result;
    assign o_dmem_we    = m_is_store;
    // WM bypass covers a store right behind the load of its data
    assign o_dmem_wdata = (m_is_store && m_rt_re && w_rf_we && w_rd == m_rt) ? w_value : m_data;

    // loaded data is not ready in M, so loads are kept off the MX path
    assign o_m_fwd_en = m_rf_we && !m_is_load;
    assign o_m_rd     = m_rd;
    assign o_m_value  = m_result;
    assign o_m_nzp_en = m_nzp_we && !m_is_load;
    assign o_m_nzp    = nzp_of(m_result);

    assign wb.we     = w_rf_we;
    assign wb.wsel   = w_rd;
    assign wb.data   = w_value;
    assign wb.nzp_we = w_nzp_we;
    assign wb.nzp    = nzp_of(w_value);

    assign o_trace_stall   = w_stall;
    assign o_trace_pc      = w_pc;
    assign o_trace_insn    = w_insn;
    assign o_trace_rf_we   = w_rf_we;
    assign o_trace_rf_wsel = w_rd;
    assign o_trace_rf_data = w_value;

endmodule

/* hdl/lc4_pkg.sv */
package lc4_pkg;

    // data value or address
    typedef logic [15:0] word_t;

    // register number
    typedef logic [2:0] rsel_t;

    // condition codes, one-hot
    typedef logic [2:0] nzp_t;

    // insn[15:12]
    typedef logic [3:0] opcode_t;

    // trace stall codes, 1 is unused without the second pipe
    typedef enum logic [1:0] {
        STALL_NONE     = 2'd0,
        STALL_FLUSH    = 2'd2,
        STALL_LOAD_USE = 2'd3
    } stall_t;

endpackage

/* hdl/lc4_regfile.sv */
`timescale 1ns/1ps

module lc4_regfile (
    input  logic           gwe,
    input  logic           i_rst_n,
    input  lc4_pkg::rsel_t i_rs_sel,
    input  lc4_pkg::rsel_t i_rt_sel,
    output lc4_pkg::word_t o_rs_data,
    output lc4_pkg::word_t o_rt_data,
    lc4_wb_if.write        wb
);
    import lc4_pkg::*;

    word_t regs [8];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.wsel] <= wb.data;
        end
    end

    // write-through so D sees the value retiring this cycle
    assign o_rs_data = (wb.we && wb.wsel == i_rs_sel) ? wb.data : regs[i_rs_sel];
    assign o_rt_data = (wb.we && wb.wsel == i_rt_sel) ? wb.data : regs[i_rt_sel];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_lc4_core -Mdir obj_dir

./obj_dir/Vtb_lc4_core

/* sources.f */
+incdir+hdl
hdl/lc4_pkg.sv
hdl/lc4_if.sv
hdl/lc4_regfile.sv
hdl/lc4_fetch_decode.sv
hdl/lc4_execute.sv
hdl/lc4_memory_wb.sv
hdl/lc4_core.sv
verif/lc4_core_assert.sv
verif/tb_lc4_core.sv

/* verif/lc4_core_assert.sv */
`timescale 1ns/1ps

module lc4_core_assert (
    input logic            gwe,
    input logic            i_rst_n,
    input logic            o_dmem_we,
    input lc4_pkg::stall_t o_trace_stall,
    input logic            o_trace_rf_we
);
    import lc4_pkg::*;

    // no store leaves M while reset is held
    assert property (@(posedge gwe) !i_rst_n |=> !o_dmem_we)
        else $error("data memory write during reset");

    // a store seen in M must show up as a real slot in W one cycle later
    assert property (@(posedge gwe) disable iff (!i_rst_n)
        o_dmem_we |=> (o_trace_stall == STALL_NONE))
        else $error("data memory write from a bubble");

    assert property (@(posedge gwe) disable iff (!i_rst_n)
        (o_trace_stall != STALL_NONE) |-> !o_trace_rf_we)
        else $error("register write from a stalled trace slot");

endmodule

bind lc4_core lc4_core_assert u_lc4_core_assert (
    .gwe           (gwe),
    .i_rst_n       (i_rst_n),
    .o_dmem_we     (o_dmem_we),
    .o_trace_stall (o_trace_stall),
    .o_trace_rf_we (o_trace_rf_we)
);

/* verif/tb_lc4_core.sv */
`timescale 1ns/1ps
`include "lc4_defs.svh"

module tb_lc4_core;
    import lc4_pkg::*;

    localparam int PROG_LEN     = 200;
    localparam int RETIRE_COUNT = 300;
    localparam int RESET_CYCLES = 10;
    localparam int MODEL_STEPS  = RETIRE_COUNT + 16;
    localparam int WATCHDOG_NS  = 8 * (RESET_CYCLES + RETIRE_COUNT) * 10;

    logic   gwe;
    logic   i_rst_n;
    word_t  o_imem_addr;
    word_t  i_imem_data;
    word_t  o_dmem_addr;
    logic   o_dmem_we;
    word_t  o_dmem_wdata;
    word_t  i_dmem_rdata;
    stall_t o_trace_stall;
    word_t  o_trace_pc;
    word_t  o_trace_insn;
    logic   o_trace_rf_we;
    rsel_t  o_trace_rf_wsel;
    word_t  o_trace_rf_data;

    word_t prog[$];
    word_t dmem[word_t];
    word_t model_mem[word_t];
    // expected retirement order from the instruction-set model
    word_t exp_pc[$];
    word_t exp_insn[$];
    logic  exp_we[$];
    rsel_t exp_wsel[$];
    word_t exp_data[$];
    int    exp_lu[$];
    word_t st_addr[$];
    word_t st_data[$];
    int    retired;
    int    lu_seen;
    logic  monitor_on;

    lc4_core u_lc4_core (.*);

    initial gwe = 1'b0;
    always #5 gwe = ~gwe;

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic word_t fetch_word(input word_t addr);
        int idx;
        idx = int'(addr) - int'(`LC4_RESET_PC);
        if (^addr === 1'bx || idx < 0 || idx >= prog.size()) begin
            return 16'h0000;
        end
        return prog[idx];
    endfunction

    function automatic word_t read_dmem(input word_t addr);
        if (^addr === 1'bx || !dmem.exists(addr)) begin
            return 16'h0000;
        end
        return dmem[addr];
    endfunction

    function automatic nzp_t sign_flags(input word_t v);
        if ($signed(v) < 0) return `LC4_NZP_N;
        if (v == 16'h0000) return `LC4_NZP_Z;
        return `LC4_NZP_P;
    endfunction

    task automatic build_program();
        int    kind;
        int    no_mem;
        int    off;
        rsel_t base;
        rsel_t ld_rd;
        logic  st_after;
        prog.push_back({`LC4_OP_CONST, 3'($urandom_range(0, 7)), 9'($urandom_range(0, 511))});
        no_mem = 0;
        while (prog.size() < PROG_LEN - 1) begin
            kind = $urandom_range(0, 7);
            // a branch must not skip the CONST that sets a base register
            if ((kind == 5 || kind == 6) && (no_mem > 0 || prog.size() > PROG_LEN - 4)) begin
                kind = 0;
            end
            base = 3'($urandom_range(0, 7));
            ld_rd = 3'($urandom_range(0, 7));
            st_after = 1'($urandom_range(0, 1));
            case (kind)
                0: prog.push_back({`LC4_OP_ARITH, 3'($urandom), 3'($urandom), `LC4_SUB_ADD,
                                   3'($urandom)});
                1: prog.push_back({`LC4_OP_ARITH, 3'($urandom), 3'($urandom), `LC4_SUB_SUB,
                                   3'($urandom)});
                2: prog.push_back({`LC4_OP_ARITH, 3'($urandom), 3'($urandom), 1'b1, 5'($urandom)});
                3: prog.push_back({`LC4_OP_LOGIC, 3'($urandom), 3'($urandom), `LC4_SUB_AND,
                                   3'($urandom)});
                4: prog.push_back({`LC4_OP_CONST, 3'($urandom), 9'($urandom)});
                5: begin
                    // the following store still needs its base register
                    if (st_after && ld_rd == base) begin
                        ld_rd = base + 3'd1;
                    end
                    prog.push_back({`LC4_OP_CONST, base, 9'($urandom_range(0, 31))});
                    prog.push_back({`LC4_OP_LDR, ld_rd, base, 6'($urandom_range(0, 31))});
                    // store of the loaded register right behind the load
                    if (st_after) begin
                        prog.push_back({`LC4_OP_STR, ld_rd, base,
                                        6'($urandom_range(0, 31))});
                    end
                end
                6: begin
                    prog.push_back({`LC4_OP_CONST, base, 9'($urandom_range(0, 31))});
                    prog.push_back({`LC4_OP_STR, 3'($urandom), base,
                                    6'($urandom_range(0, 31))});
                end
                default: begin
                    off = $urandom_range(0, 3);
                    if (prog.size() + 1 + off > PROG_LEN - 1) off = PROG_LEN - 2 - prog.size();
                    prog.push_back({`LC4_OP_BR, 3'($urandom), 9'(off)});
                    no_mem = 4;
                end
            endcase
            if (no_mem > 0) no_mem--;
        end
        // unconditional branch to itself
        prog.push_back({`LC4_OP_BR, 3'b111, 9'h1ff});
    endtask

    task automatic run_model();
        word_t   regs[8];
        word_t   pc;
        word_t   insn;
        word_t   val;
        word_t   next;
        word_t   addr;
        nzp_t    nzp;
        opcode_t op;
        rsel_t   rd;
        rsel_t   rs;
        rsel_t   rt;
        logic    we;
        logic    prev_load;
        rsel_t   prev_rd;
        logic    dep;
        for (int i = 0; i < 8; i++) regs[i] = 16'h0000;
        pc = `LC4_RESET_PC;
        nzp = `LC4_NZP_Z;
        prev_load = 1'b0;
        prev_rd = 3'd0;
        for (int k = 0; k < MODEL_STEPS; k++) begin
            insn = fetch_word(pc);
            op = insn[15:12];
            rd = insn[11:9];
            rs = insn[8:6];
            rt = insn[2:0];
            we = 1'b0;
            val = 16'h0000;
            next = pc + 16'd1;
            dep = 1'b0;
            case (op)
                `LC4_OP_ARITH: begin
                    we = 1'b1;
                    if (insn[5]) begin
                        val = regs[rs] + {{11{insn[4]}}, insn[4:0]};
                        dep = (rs == prev_rd);
                    end else begin
                        if (insn[5:3] == `LC4_SUB_SUB) begin
                            val = regs[rs] - regs[rt];
                        end else begin
                            val = regs[rs] + regs[rt];
                        end
                        dep = (rs == prev_rd) || (rt == prev_rd);
                    end
                end
                `LC4_OP_LOGIC: begin
                    we = 1'b1;
                    val = regs[rs] & regs[rt];
                    dep = (rs == prev_rd) || (rt == prev_rd);
                end
                `LC4_OP_CONST: begin
                    we = 1'b1;
                    val = {{7{insn[8]}}, insn[8:0]};
                end
                `LC4_OP_LDR: begin
                    we = 1'b1;
                    addr = regs[rs] + {{10{insn[5]}}, insn[5:0]};
                    val = model_mem.exists(addr) ? model_mem[addr] : 16'h0000;
                    dep = (rs == prev_rd);
                end
                `LC4_OP_STR: begin
                    addr = regs[rs] + {{10{insn[5]}}, insn[5:0]};
                    model_mem[addr] = regs[rd];
                    st_addr.push_back(addr);
                    st_data.push_back(regs[rd]);
                    dep = (rs == prev_rd);
                end
                default: begin
                    dep = (insn[11:9] != 3'b000);
                    if ((insn[11:9] & nzp) != 3'b000) begin
                        next = pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
                    end
                end
            endcase
            exp_pc.push_back(pc);
            exp_insn.push_back(insn);
            exp_we.push_back(we);
            exp_wsel.push_back(rd);
            exp_data.push_back(val);
            exp_lu.push_back((prev_load && dep) ? 1 : 0);
            if (we) begin
                regs[rd] = val;
                nzp = sign_flags(val);
            end
            prev_load = (op == `LC4_OP_LDR);
            prev_rd = rd;
            pc = next;
        end
    endtask

    // memory answers and store capture on the clock edges
    always @(posedge gwe) begin
        #1;
        i_imem_data = fetch_word(o_imem_addr);
        i_dmem_rdata = read_dmem(o_dmem_addr);
    end

    always @(negedge gwe) begin
        if (monitor_on) begin
            if (o_dmem_we) begin
                if (st_addr.size() == 0) begin
                    $display("a store reached data memory that the model never executed");
                    $display("CHECKS FAILED");
                    $fatal(1, "unexpected store");
                end
                check_value("store address", st_addr.pop_front(), o_dmem_addr);
                check_value("store data", st_data.pop_front(), o_dmem_wdata);
                dmem[o_dmem_addr] = o_dmem_wdata;
            end
            if (o_trace_stall == STALL_LOAD_USE) begin
                lu_seen++;
            end else if (o_trace_stall == STALL_NONE && retired < RETIRE_COUNT) begin
                check_value($sformatf("retire %0d pc", retired), exp_pc[retired], o_trace_pc);
                check_value($sformatf("retire %0d insn", retired), exp_insn[retired], o_trace_insn);
                check_value($sformatf("retire %0d rf_we", retired), 16'(exp_we[retired]),
                            16'(o_trace_rf_we));
                if (exp_we[retired]) begin
                    check_value($sformatf("retire %0d wsel", retired), 16'(exp_wsel[retired]),
                                16'(o_trace_rf_wsel));
                    check_value($sformatf("retire %0d data", retired), exp_data[retired],
                                o_trace_rf_data);
                end
                check_value($sformatf("retire %0d load-use bubbles", retired),
                            16'(exp_lu[retired]), 16'(lu_seen));
                lu_seen = 0;
                retired++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout before %0d instructions retired", RETIRE_COUNT);
        $display("CHECKS FAILED");
        $fatal(1, "run did not finish in time");
    end

    initial begin
        i_rst_n = 1'b0;
        i_imem_data = 16'h0000;
        i_dmem_rdata = 16'h0000;
        retired = 0;
        lu_seen = 0;
        monitor_on = 1'b0;
        void'($urandom(93));
        build_program();
        run_model();
        repeat (RESET_CYCLES) @(posedge gwe);
        #1;
        i_rst_n = 1'b1;
        monitor_on = 1'b1;
        @(negedge gwe);
        check_value("reset pc", `LC4_RESET_PC, o_imem_addr);
        check_value("reset dmem_we", 16'h0000, 16'(o_dmem_we));
        check_value("reset flush slot 0", 16'(STALL_FLUSH), 16'(o_trace_stall));
        for (int i = 1; i < 4; i++) begin
            @(negedge gwe);
            check_value($sformatf("reset flush slot %0d", i), 16'(STALL_FLUSH),
                        16'(o_trace_stall));
        end
        wait (retired == RETIRE_COUNT);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
